// ==== common/acore_consts.svh ====
`ifndef ACORE_CONSTS_SVH
`define ACORE_CONSTS_SVH

// interleave factor
`define NTI 8

// signed input sample width
`define NIN 10

// magnitude code width per slice
`define NADC 8

// frames held between core and serializer
`define FIFO_DEPTH 4

`endif

// ==== common/const_pack.sv ====
`default_nettype none

package const_pack;

    // configuration port opcodes
    typedef enum logic [1:0] {
        CFG_NOP           = 2'd0,
        CFG_SET_OFFSET    = 2'd1,   // load offset of one slice
        CFG_CLEAR_OFFSETS = 2'd2    // zero every slice offset
    } cfg_op_e;

    // frame assembly in the core
    typedef enum logic {
        ST_FILL = 1'b0,             // taking samples
        ST_HOLD = 1'b1              // full frame offered downstream
    } fill_state_e;

    // serializer
    typedef enum logic {
        SER_IDLE = 1'b0,
        SER_SEND = 1'b1
    } ser_state_e;

endpackage : const_pack

`default_nettype wire

// ==== analog_core/adc_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "acore_consts.svh"

module adc_slice (
    input  wire logic                   clk_adc_i,
    input  wire logic                   rst_i,
    input  wire logic                   load_i,     // sample belongs to this slice
    input  wire logic signed [`NIN-1:0] sample_i,
    input  wire logic                   off_we_i,
    input  wire logic                   off_clr_i,
    input  wire logic signed [`NIN-1:0] off_i,
    output      logic                   sign_o,
    output      logic [`NADC-1:0]       mag_o
);

    localparam logic [`NIN:0] MAG_MAX = (`NIN+1)'((1 << `NADC) - 1);

    logic signed [`NIN-1:0] offset_q;
    logic signed [`NIN:0]   diff;           // extra bit keeps the subtraction exact
    logic        [`NIN:0]   abs_diff;
    logic        [`NADC-1:0] mag_sat;

    // per-slice offset trim
    always_ff @(posedge clk_adc_i) begin
        if (rst_i || off_clr_i) begin
            offset_q <= '0;
        end else if (off_we_i) begin
            offset_q <= off_i;
        end
    end

    assign diff     = sample_i - offset_q;
    assign abs_diff = diff[`NIN] ? -diff : diff;

    // clamp to full scale of the code
    assign mag_sat = (abs_diff > MAG_MAX) ? MAG_MAX[`NADC-1:0] : abs_diff[`NADC-1:0];

    always_ff @(posedge clk_adc_i) begin
        if (load_i) begin
            sign_o <= diff[`NIN];
            mag_o  <= mag_sat;
        end
    end

    // clamping only ever shrinks the magnitude, and a negative result is never zero
    a_mag_clamp: assert property (@(posedge clk_adc_i) disable iff (rst_i)
        load_i |=> ((`NIN+1)'(mag_o) <= $past(abs_diff)) && (!sign_o || mag_o != '0));

endmodule : adc_slice

`default_nettype wire

// ==== analog_core/analog_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "acore_consts.svh"

module analog_core import const_pack::*; (
    input  wire logic                        clk_adc_i,
    input  wire logic                        rst_i,

    input  wire logic                        in_valid_i,
    input  wire logic signed [`NIN-1:0]      in_data_i,
    output      logic                        in_ready_o,

    input  wire cfg_op_e                     cfg_op_i,
    input  wire logic [$clog2(`NTI)-1:0]     cfg_addr_i,    // target slice
    input  wire logic signed [`NIN-1:0]      cfg_data_i,    // offset value

    output      logic                        frame_valid_o,
    output      logic [`NTI-1:0]             frame_sign_o,
    output      logic [`NTI*`NADC-1:0]       frame_mag_o,
    input  wire logic                        frame_ready_i
);

    localparam int AW = $clog2(`NTI);

    fill_state_e     state_q;
    logic [AW-1:0]   ptr_q;         // slice that takes the next sample
    logic            accept;
    logic            last_slot;
    logic [`NTI-1:0] load;
    logic [`NTI-1:0] off_we;
    logic            off_clr;

    assign in_ready_o    = (state_q == ST_FILL);
    assign frame_valid_o = (state_q == ST_HOLD);
    assign accept        = in_valid_i && in_ready_o;
    assign last_slot     = (ptr_q == AW'(`NTI - 1));
    assign off_clr       = (cfg_op_i == CFG_CLEAR_OFFSETS);

    always_ff @(posedge clk_adc_i) begin
        if (rst_i) begin
            state_q <= ST_FILL;
            ptr_q   <= '0;
        end else begin
            case (state_q)
                ST_FILL: begin
                    if (accept) begin
                        if (last_slot) begin
                            ptr_q   <= '0;
                            state_q <= ST_HOLD;     // frame complete
                        end else begin
                            ptr_q <= ptr_q + 1'b1;
                        end
                    end
                end
                ST_HOLD: begin
                    if (frame_ready_i) begin
                        state_q <= ST_FILL;
                    end
                end
                default: state_q <= ST_FILL;
            endcase
        end
    end

    // interleaved slices
    generate
        for (genvar k = 0; k < `NTI; k = k + 1) begin : g_slice
            assign load[k]   = accept && (ptr_q == AW'(k));
            assign off_we[k] = (cfg_op_i == CFG_SET_OFFSET) && (cfg_addr_i == AW'(k));

            adc_slice i_slice (
                .clk_adc_i (clk_adc_i),
                .rst_i     (rst_i),
                .load_i    (load[k]),
                .sample_i  (in_data_i),
                .off_we_i  (off_we[k]),
                .off_clr_i (off_clr),
                .off_i     (cfg_data_i),
                .sign_o    (frame_sign_o[k]),
                .mag_o     (frame_mag_o[k*`NADC +: `NADC])
            );
        end
    endgenerate

    a_ptr_range: assert property (@(posedge clk_adc_i) disable iff (rst_i)
        (ptr_q < AW'(`NTI - 1) || last_slot) && (state_q == ST_HOLD -> ptr_q == '0));

    // a held frame is never overwritten by new input
    a_hold_no_accept: assert property (@(posedge clk_adc_i) disable iff (rst_i)
        state_q == ST_HOLD && !frame_ready_i |=>
            state_q == ST_HOLD && $stable(frame_mag_o) && $stable(frame_sign_o));

endmodule : analog_core

`default_nettype wire

// ==== source/frame_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 72
) (
    input  wire logic             clk_adc_i,
    input  wire logic             rst_i,
    input  wire logic             wr_valid_i,
    input  wire logic [WIDTH-1:0] wr_data_i,
    output      logic             wr_ready_o,
    output      logic             rd_valid_o,
    output      logic [WIDTH-1:0] rd_data_o,
    input  wire logic             rd_ready_i
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PW-1:0]    wr_ptr_q;
    logic [PW-1:0]    rd_ptr_q;
    logic [CW-1:0]    count_q;      // frames stored
    logic             push;
    logic             pop;

    assign wr_ready_o = (count_q != CW'(DEPTH));
    assign rd_valid_o = (count_q != '0);
    assign rd_data_o  = mem[rd_ptr_q];     // head is always visible
    assign push       = wr_valid_i && wr_ready_o;
    assign pop        = rd_valid_o && rd_ready_i;

    always_ff @(posedge clk_adc_i) begin
        if (push) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_adc_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // at most DEPTH frames and a full buffer has its write pointer back on the head
    a_no_push_full: assert property (@(posedge clk_adc_i) disable iff (rst_i)
        count_q <= CW'(DEPTH) && (count_q != CW'(DEPTH) || wr_ptr_q == rd_ptr_q));

    // empty buffer keeps both pointers together
    a_no_pop_empty: assert property (@(posedge clk_adc_i) disable iff (rst_i)
        count_q == '0 |-> wr_ptr_q == rd_ptr_q);

endmodule : frame_fifo

`default_nettype wire

// ==== source/sample_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "acore_consts.svh"

module sample_serializer import const_pack::*; (
    input  wire logic                     clk_adc_i,
    input  wire logic                     rst_i,

    input  wire logic                     buf_valid_i,
    input  wire logic [`NTI-1:0]          buf_sign_i,
    input  wire logic [`NTI*`NADC-1:0]    buf_mag_i,
    output      logic                     buf_ready_o,

    output      logic                     out_valid_o,
    output      logic signed [`NADC:0]    out_data_o,
    output      logic                     out_sat_o,
    input  wire logic                     out_ready_i
);

    localparam int AW = $clog2(`NTI);

    ser_state_e            state_q;
    logic [AW-1:0]         lane_q;
    logic [`NTI-1:0]       sign_q;     // latched frame
    logic [`NTI*`NADC-1:0] mag_q;
    logic                  cur_sign;
    logic [`NADC-1:0]      cur_mag;
    logic signed [`NADC:0] mag_ext;

    assign buf_ready_o = (state_q == SER_IDLE);
    assign out_valid_o = (state_q == SER_SEND);

    assign cur_sign   = sign_q[lane_q];
    assign cur_mag    = mag_q[lane_q*`NADC +: `NADC];
    assign mag_ext    = {1'b0, cur_mag};
    assign out_data_o = cur_sign ? -mag_ext : mag_ext;   // back to two's complement
    assign out_sat_o  = (cur_mag == {`NADC{1'b1}});

    always_ff @(posedge clk_adc_i) begin
        if (buf_valid_i && buf_ready_o) begin
            sign_q <= buf_sign_i;
            mag_q  <= buf_mag_i;
        end
    end

    always_ff @(posedge clk_adc_i) begin
        if (rst_i) begin
            state_q <= SER_IDLE;
            lane_q  <= '0;
        end else begin
            case (state_q)
                SER_IDLE: begin
                    if (buf_valid_i) begin
                        lane_q  <= '0;
                        state_q <= SER_SEND;
                    end
                end
                SER_SEND: begin
                    if (out_ready_i) begin
                        if (lane_q == AW'(`NTI - 1)) begin
                            state_q <= SER_IDLE;    // frame drained
                        end else begin
                            lane_q <= lane_q + 1'b1;
                        end
                    end
                end
                default: state_q <= SER_IDLE;
            endcase
        end
    end

    // stalled output holds its sample
    a_out_stable: assert property (@(posedge clk_adc_i) disable iff (rst_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o) && $stable(out_sat_o));

endmodule : sample_serializer

`default_nettype wire

// ==== source/ti_adc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "acore_consts.svh"

module ti_adc_top import const_pack::*; (
    input  wire logic                    clk_adc_i,
    input  wire logic                    rst_i,

    input  wire logic                    in_valid_i,
    input  wire logic signed [`NIN-1:0]  in_data_i,
    output      logic                    in_ready_o,

    input  wire cfg_op_e                 cfg_op_i,
    input  wire logic [$clog2(`NTI)-1:0] cfg_addr_i,
    input  wire logic signed [`NIN-1:0]  cfg_data_i,

    output      logic                    out_valid_o,
    output      logic signed [`NADC:0]   out_data_o,
    output      logic                    out_sat_o,
    input  wire logic                    out_ready_i
);

    localparam int FW = `NTI * (`NADC + 1);    // sign bits plus codes

    logic                    frame_valid;
    logic [`NTI-1:0]         frame_sign;
    logic [`NTI*`NADC-1:0]   frame_mag;
    logic                    frame_ready;
    logic                    buf_valid;
    logic [`NTI-1:0]         buf_sign;
    logic [`NTI*`NADC-1:0]   buf_mag;
    logic                    buf_ready;

    analog_core i_core (
        .clk_adc_i     (clk_adc_i),
        .rst_i         (rst_i),
        .in_valid_i    (in_valid_i),
        .in_data_i     (in_data_i),
        .in_ready_o    (in_ready_o),
        .cfg_op_i      (cfg_op_i),
        .cfg_addr_i    (cfg_addr_i),
        .cfg_data_i    (cfg_data_i),
        .frame_valid_o (frame_valid),
        .frame_sign_o  (frame_sign),
        .frame_mag_o   (frame_mag),
        .frame_ready_i (frame_ready)
    );

    frame_fifo #(
        .DEPTH (`FIFO_DEPTH),
        .WIDTH (FW)
    ) i_fifo (
        .clk_adc_i  (clk_adc_i),
        .rst_i      (rst_i),
        .wr_valid_i (frame_valid),
        .wr_data_i  ({frame_sign, frame_mag}),
        .wr_ready_o (frame_ready),
        .rd_valid_o (buf_valid),
        .rd_data_o  ({buf_sign, buf_mag}),
        .rd_ready_i (buf_ready)
    );

    sample_serializer i_ser (
        .clk_adc_i   (clk_adc_i),
        .rst_i       (rst_i),
        .buf_valid_i (buf_valid),
        .buf_sign_i  (buf_sign),
        .buf_mag_i   (buf_mag),
        .buf_ready_o (buf_ready),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .out_sat_o   (out_sat_o),
        .out_ready_i (out_ready_i)
    );

endmodule : ti_adc_top

`default_nettype wire

// ==== verif/tb_ti_adc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "acore_consts.svh"

module tb_ti_adc import const_pack::*; ();

    localparam int AW = $clog2(`NTI);

    logic                   clk_adc_i;
    logic                   rst_i;
    logic                   in_valid_i;
    logic signed [`NIN-1:0] in_data_i;
    logic                   in_ready_o;
    cfg_op_e                cfg_op_i;
    logic [AW-1:0]          cfg_addr_i;
    logic signed [`NIN-1:0] cfg_data_i;
    logic                   out_valid_o;
    logic signed [`NADC:0]  out_data_o;
    logic                   out_sat_o;
    logic                   out_ready_i;

    integer seed = 32'ha355_2070;
    int     cycles = 0;
    int     limit = 200;        // raised once the stimulus is read
    int     errors = 0;
    int     tests = 0;
    int     failed = 0;
    bit     random_bp = 1'b0;
    bit     saw_stall = 1'b0;

    // one entry per record, a config keeps opcode, slice and offset in a/b/c
    int    kind_q[$];           // 0 config, 1 test
    string name_q[$];
    int    a_q[$];              // sample count of a test
    int    b_q[$];              // back-pressure flag of a test
    int    c_q[$];              // first sample of a test
    int    smp_q[$];
    int    exp_q[$];
    int    sat_q[$];
    int    got_q[$];
    int    got_sat_q[$];

    ti_adc_top dut0 (.*);

    initial begin
        clk_adc_i = 1'b0;
        forever #10 clk_adc_i = ~clk_adc_i;
    end

    // output back-pressure, mode taken at the edge
    initial begin
        bit use_rand;
        out_ready_i = 1'b0;
        forever begin
            @(posedge clk_adc_i);
            use_rand = random_bp;
            #2;
            out_ready_i = use_rand ? (($random(seed) & 7) == 0) : 1'b1;
        end
    end

    always @(posedge clk_adc_i) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, the outputs stopped arriving", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    always @(negedge clk_adc_i) begin
        if (out_valid_o && out_ready_i) begin     // transfer on the coming edge
            got_q.push_back(int'(out_data_o));
            got_sat_q.push_back(int'(out_sat_o));
        end
    end

    task automatic read_stimulus();
        int    fd;
        int    n;
        int    bp;
        int    x;
        int    y;
        int    z;
        int    i;
        int    total;
        string tok;
        string nm;
        string rest;
        total = 0;
        fd = $fopen("verif/ti_adc_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file verif/ti_adc_stim.txt");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok.substr(0, 0) == "#") begin
                    void'($fgets(rest, fd));
                end else if (tok == "cfg") begin
                    void'($fscanf(fd, "%d %d %d", x, y, z));
                    kind_q.push_back(0);
                    name_q.push_back(tok);
                    a_q.push_back(x);
                    b_q.push_back(y);
                    c_q.push_back(z);
                end else begin
                    void'($fscanf(fd, "%s %d %d", nm, n, bp));
                    kind_q.push_back(1);
                    name_q.push_back(nm);
                    a_q.push_back(n);
                    b_q.push_back(bp);
                    c_q.push_back(smp_q.size());
                    for (i = 0; i < n; i++) begin
                        void'($fscanf(fd, "%d %d %d", x, y, z));
                        smp_q.push_back(x);
                        exp_q.push_back(y);
                        sat_q.push_back(z);
                    end
                    total += n;
                end
            end
            $fclose(fd);
            limit = 8 * total + 200;
        end
    endtask

    task automatic apply_config(input int op, input int slice, input int off);
        cfg_op_i   = cfg_op_e'(2'(op));
        cfg_addr_i = AW'(slice);
        cfg_data_i = `NIN'(off);
        @(posedge clk_adc_i);
        #2;
        cfg_op_i = CFG_NOP;
    endtask

    task automatic send_sample(input int s);
        int low;
        low = 0;
        in_valid_i = 1'b1;
        in_data_i  = `NIN'(s);
        @(negedge clk_adc_i);
        while (!in_ready_o) begin
            low++;
            if (low >= 2) begin
                saw_stall = 1'b1;       // hold outlasted one cycle, FIFO full
            end
            @(negedge clk_adc_i);
        end
        @(posedge clk_adc_i);
        #2;
    endtask

    task automatic report_test(input string nm, input int bad);
        tests++;
        errors += bad;
        if (bad != 0) begin
            failed++;
        end
        $display("test %s %s, %0d errors", nm, (bad == 0) ? "passed" : "failed", bad);
    endtask

    task automatic run_test(input int it);
        int    first;
        int    n;
        int    bad;
        int    i;
        string nm;
        first = c_q[it];
        n     = a_q[it];
        nm    = name_q[it];
        bad   = 0;
        got_q.delete();
        got_sat_q.delete();
        saw_stall = 1'b0;
        random_bp = (b_q[it] != 0);
        for (i = 0; i < n; i++) begin
            send_sample(smp_q[first + i]);
        end
        in_valid_i = 1'b0;
        while (got_q.size() < n) begin
            @(negedge clk_adc_i);
        end
        random_bp = 1'b0;
        repeat (4) @(negedge clk_adc_i);    // room for stray extra outputs
        assert (got_q.size() == n) else begin
            $display("%s delivered %0d samples but %0d were sent", nm, got_q.size(), n);
            bad++;
        end
        for (i = 0; i < n; i++) begin
            assert (got_q[i] == exp_q[first + i]) else begin
                $display("Mismatch %s sample %0d: expected %0d, actual %0d",
                         nm, i, exp_q[first + i], got_q[i]);
                bad++;
            end
            assert (got_sat_q[i] == sat_q[first + i]) else begin
                $display("Mismatch %s sample %0d saturation: expected %0d, actual %0d",
                         nm, i, sat_q[first + i], got_sat_q[i]);
                bad++;
            end
        end
        if (b_q[it] != 0) begin
            assert (saw_stall) else begin
                $display("%s never blocked the input while the output was throttled", nm);
                bad++;
            end
        end
        report_test(nm, bad);
    endtask

    initial begin
        int it;
        int bad;
        rst_i      = 1'b1;
        in_valid_i = 1'b0;
        in_data_i  = '0;
        cfg_op_i   = CFG_NOP;
        cfg_addr_i = '0;
        cfg_data_i = '0;
        read_stimulus();
        repeat (10) @(posedge clk_adc_i);
        #2;
        rst_i = 1'b0;
        bad = 0;
        repeat (5) begin        // nothing may come out before any input
            @(negedge clk_adc_i);
            assert (!out_valid_o && in_ready_o) else begin
                $display("Mismatch idle: expected valid 0 ready 1, actual valid %0b ready %0b",
                         out_valid_o, in_ready_o);
                bad++;
            end
        end
        report_test("idle", bad);
        for (it = 0; it < kind_q.size(); it++) begin
            @(posedge clk_adc_i);
            #2;
            if (kind_q[it] == 0) begin
                apply_config(a_q[it], b_q[it], c_q[it]);
            end else begin
                run_test(it);
            end
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 tests, tests - failed, failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : tb_ti_adc

`default_nettype wire

// ==== verif/ti_adc_stim.txt ====
# cfg <opcode> <slice> <offset>    opcode 1 sets one slice offset, 2 clears all offsets
# test <name> <count> <backpressure>, then <count> triples of <sample> <expected> <sat>
test identity 8 0
12 12 0  -7 -7 0  100 100 0  -100 -100 0  0 0 0  200 200 0  -200 -200 0  1 1 0
cfg 1 0 10
cfg 1 3 -20
cfg 1 5 100
test offsets 8 0
50 40 0  50 50 0  50 50 0  50 70 0  50 50 0  50 -50 0  50 50 0  50 50 0
test saturate 8 0
511 255 1  -512 -255 1  300 255 1  -300 -255 1  255 255 1  0 -100 0  256 255 1  -254 -254 0
cfg 2 0 0
test cleared 8 0
10 10 0  -10 -10 0  20 20 0  -20 -20 0  30 30 0  -30 -30 0  40 40 0  -40 -40 0
test burst 64 1
1 1 0  -2 -2 0  3 3 0  -4 -4 0  50 50 0  -60 -60 0  70 70 0  -80 -80 0
255 255 1  -255 -255 1  300 255 1  -400 -255 1  9 9 0  -9 -9 0  128 128 0  -128 -128 0
11 11 0  22 22 0  33 33 0  44 44 0  55 55 0  66 66 0  77 77 0  88 88 0
-11 -11 0  -22 -22 0  -33 -33 0  -44 -44 0  -55 -55 0  -66 -66 0  -77 -77 0  -88 -88 0
254 254 0  -254 -254 0  256 255 1  -256 -255 1  511 255 1  -512 -255 1  0 0 0  1 1 0
100 100 0  -101 -101 0  102 102 0  -103 -103 0  104 104 0  -105 -105 0  106 106 0  -107 -107 0
5 5 0  15 15 0  25 25 0  35 35 0  45 45 0  -5 -5 0  -15 -15 0  -25 -25 0
200 200 0  -200 -200 0  210 210 0  -210 -210 0  220 220 0  -220 -220 0  230 230 0  -230 -230 0

// ==== all.f ====
+incdir+common
common/const_pack.sv
analog_core/adc_slice.sv
analog_core/analog_core.sv
source/frame_fifo.sv
source/sample_serializer.sv
source/ti_adc_top.sv
verif/tb_ti_adc.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and pass only if the run reports success
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f all.f \
        --top-module tb_ti_adc -o sim_tb_ti_adc \
    && ./obj_dir/sim_tb_ti_adc | tee /dev/stderr | grep -q "Test OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
